// ==== hw/itlb_pkg.sv ====
package itlb_pkg;

  // Address and entry widths
  parameter int VPN_WIDTH = 27;
  parameter int PPN_WIDTH = 44;
  parameter int ASID_WIDTH = 16;
  parameter int PTE_WIDTH = 64;
  parameter int PAGE_LVL_WIDTH = 2;
  parameter int EXCP_CAUSE_WIDTH = 5;
  parameter int VPN_SEG_WIDTH = 9;
  parameter int SV39_LEVELS = 3;

  // satp.MODE encodings
  parameter logic [3:0] MODE_BARE = 4'd0;
  parameter logic [3:0] MODE_SV39 = 4'd8;

  parameter logic [1:0] PRIV_LVL_M = 2'd3;
  parameter logic [1:0] PRIV_LVL_S = 2'd1;
  parameter logic [1:0] PRIV_LVL_U = 2'd0;

  // mcause values for instruction fetch
  parameter logic [EXCP_CAUSE_WIDTH-1:0] INSTR_ACCESS_FAULT = 5'd1;
  parameter logic [EXCP_CAUSE_WIDTH-1:0] INSTR_PAGE_FAULT = 5'd12;

  typedef struct packed {
    logic [PTE_WIDTH-PPN_WIDTH-11:0] reserved;
    logic [PPN_WIDTH-1:0] ppn;
    logic [1:0] rsw;
    logic d;
    logic a;
    logic g;
    logic u;
    logic x;
    logic w;
    logic r;
    logic v;
  } pte_t;

  typedef struct packed {
    logic [1:0] priv_lvl;
    logic sum;
    logic [3:0] satp_mode;
    logic [ASID_WIDTH-1:0] satp_asid;
  } mmu_status_t;

  // Response from the page table walker
  typedef struct packed {
    logic vld;
    logic [VPN_WIDTH-1:0] vpn;
    logic [ASID_WIDTH-1:0] asid;
    pte_t pte;
    logic [PAGE_LVL_WIDTH-1:0] page_lvl;
    logic access_fault;
    logic page_fault;
  } refill_t;

  typedef struct packed {
    logic vld;
    logic use_asid;
    logic use_vpn;
    logic [ASID_WIDTH-1:0] asid;
    logic [VPN_WIDTH-1:0] vpn;
  } flush_req_t;

  typedef struct packed {
    logic vld;
    logic [VPN_WIDTH-1:0] vpn;
    logic [ASID_WIDTH-1:0] asid;
  } translate_req_t;

  typedef struct packed {
    logic hit;
    logic [PAGE_LVL_WIDTH-1:0] page_lvl;
    logic [PPN_WIDTH-1:0] ppn;
    logic a;
    logic u;
    logic x;
  } entry_match_t;

  typedef struct packed {
    logic hit;
    logic access_fault;
    logic page_fault;
  } excp_match_t;

  typedef struct packed {
    logic vld;
    logic hit;
    logic miss;
    logic excp_vld;
    logic [EXCP_CAUSE_WIDTH-1:0] excp_cause;
    logic [PPN_WIDTH-1:0] ppn;
  } translate_resp_t;

  // VPN compare mask, one segment per level at or above the page level
  function automatic logic [VPN_WIDTH-1:0] page_vpn_mask(
    input logic [3:0] satp_mode,
    input logic [PAGE_LVL_WIDTH-1:0] page_lvl
  );
    logic [VPN_WIDTH-1:0] mask;
    mask = '0;
    for (int i = 0; i < SV39_LEVELS; i++) begin
      if ((satp_mode == MODE_SV39) && (i >= page_lvl)) begin
        mask[i*VPN_SEG_WIDTH+:VPN_SEG_WIDTH] = '1;
      end
    end
    return mask;
  endfunction

endpackage

// ==== hw/itlb_entry_array.sv ====
`timescale 1ns/1ns

module itlb_entry_array #(
  parameter int ENTRY_COUNT = 8
) (
  input  logic                    clk,
  input  logic                    arst_n_i,
  input  itlb_pkg::translate_req_t req_i,
  input  logic [3:0]              satp_mode_i,
  input  itlb_pkg::refill_t       refill_i,
  input  itlb_pkg::flush_req_t    flush_i,
  output itlb_pkg::entry_match_t  match_o
);

  localparam int PTR_WIDTH = $clog2(ENTRY_COUNT);

  typedef struct packed {
    logic [itlb_pkg::ASID_WIDTH-1:0] asid;
    logic [itlb_pkg::VPN_WIDTH-1:0] vpn;
    logic [itlb_pkg::PAGE_LVL_WIDTH-1:0] page_lvl;
    logic [itlb_pkg::PPN_WIDTH-1:0] ppn;
    logic a;
    logic u;
    logic x;
    logic g;
  } entry_t;

  entry_t entry_q [ENTRY_COUNT];
  logic [ENTRY_COUNT-1:0] entry_vld_q;

  itlb_pkg::refill_t stage_q;
  logic stage_vld_q;
  logic [ENTRY_COUNT-1:0] slot_q;
  logic [PTR_WIDTH-1:0] victim_ptr_q;

  logic refill_ok;
  logic evict;
  logic [ENTRY_COUNT-1:0] occupied;
  logic [ENTRY_COUNT-1:0] free;
  logic [ENTRY_COUNT-1:0] free_oh;
  logic [ENTRY_COUNT-1:0] victim_oh;
  logic [ENTRY_COUNT-1:0] slot_d;
  logic [ENTRY_COUNT-1:0] set_mask;
  logic [ENTRY_COUNT-1:0] clear_mask;
  logic [ENTRY_COUNT-1:0] hit_vec;
  entry_t stage_entry;
  entry_t hit_entry;

  // Faulting refills go to the exception entry instead
  assign refill_ok = refill_i.vld & ~refill_i.access_fault & ~refill_i.page_fault;

  // A slot with a write still pending counts as taken
  assign occupied = entry_vld_q | (slot_q & {ENTRY_COUNT{stage_vld_q}});
  assign free = ~occupied;
  assign free_oh = free & (~free + ENTRY_COUNT'(1));
  assign victim_oh = ENTRY_COUNT'(1) << victim_ptr_q;
  assign evict = ~|free;
  assign slot_d = evict ? victim_oh : free_oh;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      stage_vld_q <= 1'b0;
      victim_ptr_q <= '0;
    end else begin
      stage_vld_q <= refill_ok;
      if (refill_ok && evict) begin
        victim_ptr_q <= (victim_ptr_q == PTR_WIDTH'(ENTRY_COUNT - 1)) ? '0 : victim_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (refill_ok) begin
      stage_q <= refill_i;
      slot_q <= slot_d;
    end
  end

  assign stage_entry = '{
    asid: stage_q.asid,
    vpn: stage_q.vpn,
    page_lvl: stage_q.page_lvl,
    ppn: stage_q.pte.ppn,
    a: stage_q.pte.a,
    u: stage_q.pte.u,
    x: stage_q.pte.x,
    g: stage_q.pte.g
  };

  // Flush wins over a write on the same edge
  assign set_mask = slot_q & {ENTRY_COUNT{stage_vld_q & ~flush_i.vld}};

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      entry_vld_q <= '0;
    end else begin
      entry_vld_q <= (entry_vld_q & ~clear_mask) | set_mask;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < ENTRY_COUNT; i++) begin
      if (set_mask[i]) begin
        entry_q[i] <= stage_entry;
      end
    end
  end

  for (genvar i = 0; i < ENTRY_COUNT; i++) begin : g_entry
    logic [itlb_pkg::VPN_WIDTH-1:0] vpn_mask;
    logic req_vpn_eq;
    logic flush_vpn_eq;
    logic flush_asid_eq;
    logic flush_sel;

    assign vpn_mask = itlb_pkg::page_vpn_mask(satp_mode_i, entry_q[i].page_lvl);
    assign req_vpn_eq = &(~(req_i.vpn ^ entry_q[i].vpn) | ~vpn_mask);
    assign hit_vec[i] = req_i.vld & entry_vld_q[i] & req_vpn_eq &
                        ((req_i.asid == entry_q[i].asid) | entry_q[i].g);

    assign flush_vpn_eq = &(~(flush_i.vpn ^ entry_q[i].vpn) | ~vpn_mask);
    assign flush_asid_eq = flush_i.asid == entry_q[i].asid;
    assign flush_sel = (~flush_i.use_asid | flush_asid_eq) & (~flush_i.use_vpn | flush_vpn_eq);
    // No selector means flush everything, global pages too
    assign clear_mask[i] = flush_i.vld & ((~flush_i.use_asid & ~flush_i.use_vpn) |
                                          (~entry_q[i].g & flush_sel));
  end

  // One-hot select of the hit entry
  always_comb begin
    hit_entry = '0;
    for (int i = 0; i < ENTRY_COUNT; i++) begin
      hit_entry = hit_entry | (entry_q[i] & {$bits(entry_t){hit_vec[i]}});
    end
  end

  assign match_o.hit = |hit_vec;
  assign match_o.page_lvl = hit_entry.page_lvl;
  assign match_o.ppn = hit_entry.ppn;
  assign match_o.a = hit_entry.a;
  assign match_o.u = hit_entry.u;
  assign match_o.x = hit_entry.x;

endmodule

// ==== hw/itlb_excp_entry.sv ====
`timescale 1ns/1ns

module itlb_excp_entry (
  input  logic                    clk,
  input  logic                    arst_n_i,
  input  itlb_pkg::translate_req_t req_i,
  input  logic [3:0]              satp_mode_i,
  input  itlb_pkg::refill_t       refill_i,
  input  logic                    flush_vld_i,
  output itlb_pkg::excp_match_t   match_o
);

  logic vld_q;
  logic [itlb_pkg::VPN_WIDTH-1:0] vpn_q;
  logic [itlb_pkg::ASID_WIDTH-1:0] asid_q;
  logic [itlb_pkg::PAGE_LVL_WIDTH-1:0] page_lvl_q;
  logic access_fault_q;
  logic page_fault_q;

  logic wr_en;
  logic [itlb_pkg::VPN_WIDTH-1:0] vpn_mask;

  assign wr_en = refill_i.vld & (refill_i.access_fault | refill_i.page_fault);

  // Any flush drops the cached fault
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vld_q <= 1'b0;
    end else if (flush_vld_i) begin
      vld_q <= 1'b0;
    end else if (wr_en) begin
      vld_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      vpn_q <= refill_i.vpn;
      asid_q <= refill_i.asid;
      page_lvl_q <= refill_i.page_lvl;
      access_fault_q <= refill_i.access_fault;
      page_fault_q <= refill_i.page_fault;
    end
  end

  // No global bit here, the ASID must match
  assign vpn_mask = itlb_pkg::page_vpn_mask(satp_mode_i, page_lvl_q);
  assign match_o.hit = req_i.vld & vld_q & (req_i.asid == asid_q) &
                       (&(~(req_i.vpn ^ vpn_q) | ~vpn_mask));
  assign match_o.access_fault = access_fault_q;
  assign match_o.page_fault = page_fault_q;

endmodule

// ==== hw/itlb_resp_gen.sv ====
`timescale 1ns/1ns

module itlb_resp_gen (
  input  itlb_pkg::translate_req_t   req_i,
  input  itlb_pkg::mmu_status_t      status_i,
  input  itlb_pkg::entry_match_t     entry_i,
  input  itlb_pkg::excp_match_t      excp_i,
  output itlb_pkg::translate_resp_t  resp_o
);

  logic skip;
  logic user_ok;
  logic misaligned;
  logic check_fail;
  logic [itlb_pkg::PPN_WIDTH-1:0] low_mask;
  logic [itlb_pkg::PPN_WIDTH-1:0] vpn_ext;

  // Machine mode and Bare mode pass the VPN straight through
  assign skip = (status_i.priv_lvl == itlb_pkg::PRIV_LVL_M) |
                (status_i.satp_mode == itlb_pkg::MODE_BARE);

  assign vpn_ext = {{(itlb_pkg::PPN_WIDTH - itlb_pkg::VPN_WIDTH){1'b0}}, req_i.vpn};

  // PPN bits below the page level come from the VPN
  assign low_mask = ~({itlb_pkg::PPN_WIDTH{1'b1}} <<
                      (entry_i.page_lvl * itlb_pkg::VPN_SEG_WIDTH));

  assign user_ok = ~entry_i.u |
                   (status_i.priv_lvl == itlb_pkg::PRIV_LVL_U) |
                   ((status_i.priv_lvl == itlb_pkg::PRIV_LVL_S) & status_i.sum);

  // Superpage PPN must be aligned to its level
  assign misaligned = |(entry_i.ppn & low_mask);

  assign check_fail = entry_i.hit & (~entry_i.a | ~entry_i.x | ~user_ok | misaligned);

  always_comb begin
    resp_o = '0;
    resp_o.vld = req_i.vld;
    if (skip) begin
      resp_o.hit = 1'b1;
      resp_o.ppn = vpn_ext;
    end else begin
      resp_o.hit = excp_i.hit | entry_i.hit;
      resp_o.excp_vld = excp_i.hit | check_fail;
      if (excp_i.hit && excp_i.access_fault) begin
        resp_o.excp_cause = itlb_pkg::INSTR_ACCESS_FAULT;
      end else if (resp_o.excp_vld) begin
        resp_o.excp_cause = itlb_pkg::INSTR_PAGE_FAULT;
      end
      if (entry_i.hit) begin
        resp_o.ppn = (entry_i.ppn & ~low_mask) | (vpn_ext & low_mask);
      end
    end
    resp_o.miss = ~resp_o.hit;
  end

endmodule

// ==== hw/itlb_top.sv ====
`timescale 1ns/1ns

module itlb_top #(
  parameter int ENTRY_COUNT = 8
) (
  input  logic                               clk,
  input  logic                               arst_n_i,
  input  itlb_pkg::mmu_status_t              status_i,
  input  logic                               translate_vld_i,
  input  logic [itlb_pkg::VPN_WIDTH-1:0]     translate_vpn_i,
  input  itlb_pkg::refill_t                  refill_i,
  input  itlb_pkg::flush_req_t               flush_i,
  output itlb_pkg::translate_resp_t          translate_resp_o,
  output logic                               flush_grant_o
);

  logic req_vld_q;
  logic [itlb_pkg::VPN_WIDTH-1:0] req_vpn_q;
  logic [itlb_pkg::ASID_WIDTH-1:0] req_asid_q;

  itlb_pkg::translate_req_t req;
  itlb_pkg::entry_match_t entry_match;
  itlb_pkg::excp_match_t excp_match;

  // Request stage, one lookup per cycle
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_vld_q <= 1'b0;
    end else begin
      req_vld_q <= translate_vld_i;
    end
  end

  always_ff @(posedge clk) begin
    if (translate_vld_i) begin
      req_vpn_q <= translate_vpn_i;
      req_asid_q <= status_i.satp_asid;
    end
  end

  assign req = '{vld: req_vld_q, vpn: req_vpn_q, asid: req_asid_q};

  // Grant one cycle after the flush
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      flush_grant_o <= 1'b0;
    end else begin
      flush_grant_o <= flush_i.vld;
    end
  end

  itlb_entry_array #(
    .ENTRY_COUNT(ENTRY_COUNT)
  ) u_entry_array (
    .clk(clk),
    .arst_n_i(arst_n_i),
    .req_i(req),
    .satp_mode_i(status_i.satp_mode),
    .refill_i(refill_i),
    .flush_i(flush_i),
    .match_o(entry_match)
  );

  itlb_excp_entry u_excp_entry (
    .clk(clk),
    .arst_n_i(arst_n_i),
    .req_i(req),
    .satp_mode_i(status_i.satp_mode),
    .refill_i(refill_i),
    .flush_vld_i(flush_i.vld),
    .match_o(excp_match)
  );

  itlb_resp_gen u_resp_gen (
    .req_i(req),
    .status_i(status_i),
    .entry_i(entry_match),
    .excp_i(excp_match),
    .resp_o(translate_resp_o)
  );

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Reset held low for 10 cycles, released away from the rising edge
  initial begin
    arst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

// ==== testbench/itlb_properties.sv ====
`timescale 1ns/1ns

module itlb_properties (
  input logic                      clk_i,
  input logic                      arst_n_i,
  input logic                      translate_vld_i,
  input itlb_pkg::translate_resp_t resp_i,
  input logic                      flush_vld_i,
  input logic                      flush_grant_i
);

  // One response per request, exactly one cycle later
  a_resp_follows_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_i.vld == $past(translate_vld_i))
    else $error("Response valid does not follow the request strobe by one cycle");

  a_miss_is_not_hit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_i.vld |-> (resp_i.miss == !resp_i.hit))
    else $error("Response miss is not the inverse of hit");

  a_excp_needs_hit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (resp_i.vld && resp_i.excp_vld) |-> resp_i.hit)
    else $error("Exception reported without hit");

  a_grant_follows_flush: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flush_grant_i == $past(flush_vld_i))
    else $error("Flush grant does not follow the flush by one cycle");

endmodule

bind itlb_top itlb_properties u_properties (
  .clk_i(clk),
  .arst_n_i(arst_n_i),
  .translate_vld_i(translate_vld_i),
  .resp_i(translate_resp_o),
  .flush_vld_i(flush_i.vld),
  .flush_grant_i(flush_grant_o)
);

// ==== testbench/itlb_tb.sv ====
`timescale 1ns/1ns

module itlb_tb;

  localparam int ENTRY_COUNT = 8;
  localparam int WAIT_LIMIT = 20;

  logic clk;
  logic arst_n;
  itlb_pkg::mmu_status_t status;
  logic translate_vld;
  logic [itlb_pkg::VPN_WIDTH-1:0] translate_vpn;
  itlb_pkg::refill_t refill;
  itlb_pkg::flush_req_t flush;
  itlb_pkg::translate_resp_t resp;
  logic flush_grant;
  int check_count;

  tb_clock_gen u_clock_gen (
    .clk_o(clk),
    .arst_n_o(arst_n)
  );

  itlb_top #(
    .ENTRY_COUNT(ENTRY_COUNT)
  ) UUT (
    .clk(clk),
    .arst_n_i(arst_n),
    .status_i(status),
    .translate_vld_i(translate_vld),
    .translate_vpn_i(translate_vpn),
    .refill_i(refill),
    .flush_i(flush),
    .translate_resp_o(resp),
    .flush_grant_o(flush_grant)
  );

  task automatic stop_on_failure();
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_resp(input string name, input itlb_pkg::translate_resp_t exp,
                            input itlb_pkg::translate_resp_t act);
    check_count++;
    if (act !== exp) begin
      $display("[ERROR] %s: expected vld=%b hit=%b miss=%b excp=%b cause=%0d ppn=%h",
               name, exp.vld, exp.hit, exp.miss, exp.excp_vld, exp.excp_cause, exp.ppn);
      $display("[ERROR] %s: actual   vld=%b hit=%b miss=%b excp=%b cause=%0d ppn=%h",
               name, act.vld, act.hit, act.miss, act.excp_vld, act.excp_cause, act.ppn);
      stop_on_failure();
    end
  endtask

  task automatic check_grant(input string name, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      stop_on_failure();
    end
  endtask

  // Strobe one request, then wait for its response
  task automatic run_translate(input string name, input itlb_pkg::mmu_status_t st,
                               input logic [itlb_pkg::VPN_WIDTH-1:0] vpn,
                               input itlb_pkg::translate_resp_t exp);
    int cycles;
    status = st;
    translate_vpn = vpn;
    translate_vld = 1'b1;
    @(negedge clk);
    translate_vld = 1'b0;
    cycles = 0;
    while (resp.vld !== 1'b1 && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (resp.vld !== 1'b1) begin
      $display("Timeout: no translation response for %s", name);
      stop_on_failure();
    end
    check_resp(name, exp, resp);
  endtask

  // Idle cycle after the strobe lets the staged write land
  task automatic run_refill(input itlb_pkg::refill_t r);
    refill = r;
    @(negedge clk);
    refill.vld = 1'b0;
    @(negedge clk);
  endtask

  task automatic run_flush(input itlb_pkg::flush_req_t f);
    flush = f;
    @(negedge clk);
    flush.vld = 1'b0;
  endtask

  // Grant is due in the cycle right after the flush edge
  task automatic run_grant_check(input string name);
    check_grant(name, 1'b1, flush_grant);
    @(negedge clk);
    check_grant({name, "_pulse_end"}, 1'b0, flush_grant);
  endtask

  task automatic report_bad_line(input string line);
    $display("Malformed stimulus line: %s", line);
    stop_on_failure();
  endtask

  initial begin
    int fd;
    int n;
    int cycles;
    string line;
    string kind;
    string name;
    logic [63:0] fld [10];
    itlb_pkg::refill_t r;
    itlb_pkg::flush_req_t f;
    itlb_pkg::mmu_status_t st;
    itlb_pkg::translate_resp_t exp;

    status = '{priv_lvl: itlb_pkg::PRIV_LVL_S, sum: 1'b0,
               satp_mode: itlb_pkg::MODE_SV39, satp_asid: '0};
    translate_vld = 1'b0;
    translate_vpn = '0;
    refill = '0;
    flush = '0;
    check_count = 0;

    cycles = 0;
    while (arst_n !== 1'b1 && cycles < 4 * WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (arst_n !== 1'b1) begin
      $display("Timeout: reset was never released");
      stop_on_failure();
    end
    @(negedge clk);

    fd = $fopen("testbench/itlb_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file");
      stop_on_failure();
    end

    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%s %s", kind, name);
      if (kind == "R") begin
        n = $sscanf(line, "%s %s %h %h %h %h %h %h", kind, name,
                    fld[0], fld[1], fld[2], fld[3], fld[4], fld[5]);
        if (n != 8) report_bad_line(line);
        r = '{vld: 1'b1, vpn: fld[0][26:0], asid: fld[1][15:0], pte: fld[2],
              page_lvl: fld[3][1:0], access_fault: fld[4][0], page_fault: fld[5][0]};
        run_refill(r);
      end else if (kind == "F") begin
        n = $sscanf(line, "%s %s %h %h %h %h", kind, name, fld[0], fld[1], fld[2], fld[3]);
        if (n != 6) report_bad_line(line);
        f = '{vld: 1'b1, use_asid: fld[0][0], use_vpn: fld[1][0],
              asid: fld[2][15:0], vpn: fld[3][26:0]};
        run_flush(f);
      end else if (kind == "T") begin
        n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h", kind, name,
                    fld[0], fld[1], fld[2], fld[3], fld[4],
                    fld[5], fld[6], fld[7], fld[8], fld[9]);
        if (n != 12) report_bad_line(line);
        st = '{priv_lvl: fld[0][1:0], sum: fld[1][0], satp_mode: fld[2][3:0],
               satp_asid: fld[3][15:0]};
        exp = '{vld: 1'b1, hit: fld[5][0], miss: fld[6][0], excp_vld: fld[7][0],
                excp_cause: fld[8][4:0], ppn: fld[9][43:0]};
        run_translate(name, st, fld[4][26:0], exp);
      end else if (kind == "G") begin
        run_grant_check(name);
      end else begin
        report_bad_line(line);
      end
    end
    $fclose(fd);

    if (check_count == 0) begin
      $display("No checks were found in the stimulus file");
      stop_on_failure();
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

// ==== testbench/itlb_stimulus.txt ====
# All numbers hex. R name vpn asid pte lvl access_fault page_fault | F name use_asid use_vpn asid vpn
# T name priv sum mode asid vpn hit miss excp_vld cause ppn | G name
T bypass_m 3 0 8 1 0012345 1 0 0 00 0012345
T bypass_bare 1 0 0 1 7abcdef 1 0 0 00 7abcdef
T miss_empty 1 0 8 1 0000100 0 1 0 00 0
R page_4k 0000100 1 4004b 0 0 0
T hit_4k 1 0 8 1 0000100 1 0 0 00 100
T miss_other_asid 1 0 8 2 0000100 0 1 0 00 0
R page_2m 0000200 1 8006b 1 0 0
T hit_2m 1 0 8 1 0000237 1 0 0 00 237
T hit_2m_global 1 0 8 5 00003ff 1 0 0 00 3ff
R no_access 0001000 1 10000b 0 0 0
T fault_no_access 1 0 8 1 0001000 1 0 1 0c 400
R no_exec 0002000 1 140043 0 0 0
T fault_no_exec 1 0 8 1 0002000 1 0 1 0c 500
R user_page 0003000 1 18005b 0 0 0
T fault_user_from_s 1 0 8 1 0003000 1 0 1 0c 600
T user_from_s_sum 1 1 8 1 0003000 1 0 0 00 600
T user_from_u 0 0 8 1 0003000 1 0 0 00 600
R misaligned_2m 0004000 1 8044b 1 0 0
T fault_misaligned 1 0 8 1 0004005 1 0 1 0c 205
R access_fault 0005000 1 0 0 1 0
T excp_access 1 0 8 1 0005000 1 0 1 01 0
R page_fault 0006000 1 0 0 0 1
T excp_page 1 0 8 1 0006000 1 0 1 0c 0
T excp_replaced 1 0 8 1 0005000 0 1 0 00 0
R page_asid2 0007000 2 1c004b 0 0 0
T hit_asid2 1 0 8 2 0007000 1 0 0 00 700
F flush_asid1 1 0 1 0
G grant_asid1
T flushed_4k 1 0 8 1 0000100 0 1 0 00 0
T kept_global 1 0 8 1 0000237 1 0 0 00 237
T kept_asid2 1 0 8 2 0007000 1 0 0 00 700
T excp_flushed 1 0 8 1 0006000 0 1 0 00 0
F flush_vpn 0 1 0 0007000
G grant_vpn
T flushed_vpn 1 0 8 2 0007000 0 1 0 00 0
T kept_global_vpn 1 0 8 2 0000200 1 0 0 00 200
R access_fault_2 0005000 1 0 0 1 0
F flush_all 0 0 0 0
G grant_all
T flushed_global 1 0 8 1 0000237 0 1 0 00 0
T excp_flushed_all 1 0 8 1 0005000 0 1 0 00 0
R fill_1 0020001 3 40004b 0 0 0
R fill_2 0020002 3 80004b 0 0 0
R fill_3 0020003 3 c0004b 0 0 0
R fill_4 0020004 3 100004b 0 0 0
R fill_5 0020005 3 140004b 0 0 0
R fill_6 0020006 3 180004b 0 0 0
R fill_7 0020007 3 1c0004b 0 0 0
R fill_8 0020008 3 200004b 0 0 0
R fill_9 0020009 3 240004b 0 0 0
T evicted_1 1 0 8 3 0020001 0 1 0 00 0
T kept_2 1 0 8 3 0020002 1 0 0 00 2000
T kept_3 1 0 8 3 0020003 1 0 0 00 3000
T kept_4 1 0 8 3 0020004 1 0 0 00 4000
T kept_5 1 0 8 3 0020005 1 0 0 00 5000
T kept_6 1 0 8 3 0020006 1 0 0 00 6000
T kept_7 1 0 8 3 0020007 1 0 0 00 7000
T kept_8 1 0 8 3 0020008 1 0 0 00 8000
T kept_9 1 0 8 3 0020009 1 0 0 00 9000

// ==== project.f ====
hw/itlb_pkg.sv
hw/itlb_entry_array.sv
hw/itlb_excp_entry.sv
hw/itlb_resp_gen.sv
hw/itlb_top.sv
testbench/tb_clock_gen.sv
testbench/itlb_properties.sv
testbench/itlb_tb.sv
